// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_fe
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "^Test passed$$" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+rtl
rtl/fe_pkg.sv
rtl/fe_fb_if.sv
rtl/fe_ctl.sv
rtl/fb_line.sv
rtl/fb_fill.sv
rtl/fb_read.sv
rtl/fe_top.sv
tb/tb_fe_mem.sv
tb/tb_fe.sv

// ==== rtl/fb_fill.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module fb_fill
    import fe_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fill_req,
    input  t_line_tag                          fill_tag,
    output logic                               fill_busy,
    output logic [`FE_LINES-1:0]               line_sel,
    output logic [$clog2(`FE_LINE_WORDS)-1:0]  wr_word_idx,
    output t_rv_instr                          wr_data,
    output t_line_tag                          wr_tag,
    output logic                               set_valid,
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic                               wb_we,
    output t_paddr                             wb_adr,
    input  logic [31:0]                        wb_dat_i,
    input  logic                               wb_ack
);

    localparam int VICT_W = $clog2(`FE_LINES);
    localparam int WORD_W = $clog2(`FE_LINE_WORDS);

    logic              busy;
    logic [VICT_W-1:0] victim;
    logic [WORD_W-1:0] word_cnt;
    t_line_tag         tag_q;
    logic              last_word;

    assign last_word = (word_cnt == WORD_W'(`FE_LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            victim   <= '0;
            word_cnt <= '0;
        end else if (!busy) begin
            if (fill_req) begin
                busy     <= 1'b1;
                word_cnt <= '0;
            end
        end else if (wb_ack) begin
            word_cnt <= word_cnt + 1'b1;
            if (last_word) begin
                busy <= 1'b0;
                // Round-robin replacement
                if (victim == VICT_W'(`FE_LINES - 1)) begin
                    victim <= '0;
                end else begin
                    victim <= victim + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && fill_req) begin
            tag_q <= fill_tag;
        end
    end

    always_comb begin
        for (int i = 0; i < `FE_LINES; i++) begin
            line_sel[i] = busy && (victim == VICT_W'(i));
        end
    end

    assign fill_busy   = busy;
    assign wr_word_idx = word_cnt;
    assign wr_data     = wb_dat_i;
    assign wr_tag      = tag_q;
    assign set_valid   = busy & wb_ack & last_word;

    // One read per word, cyc stays up across the line
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = 1'b0;
    assign wb_adr = {tag_q, word_cnt, 2'b00};

endmodule

`default_nettype wire

// ==== rtl/fb_line.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module fb_line
    import fe_pkg::*;
(
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_en,
    input  logic [$clog2(`FE_LINE_WORDS)-1:0]  wr_word_idx,
    input  t_rv_instr                          wr_data,
    input  t_line_tag                          wr_tag,
    input  logic                               set_valid,
    output logic                               line_valid,
    output t_line_tag                          line_tag,
    output t_rv_instr                          line_words [`FE_LINE_WORDS]
);

    // Line drops out of the lookup for the whole refill
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= 1'b0;
        end else if (wr_en) begin
            line_valid <= set_valid;
        end
    end

    // Slot follows the bus until ack, the acked word is what stays
    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_tag                 <= wr_tag;
            line_words[wr_word_idx]  <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fb_read.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module fb_read
    import fe_pkg::*;
(
    fe_fb_if.fb                    fb,
    input  logic [`FE_LINES-1:0]   line_valid,
    input  t_line_tag              line_tag [`FE_LINES],
    input  t_rv_instr              line_words [`FE_LINES][`FE_LINE_WORDS],
    input  logic                   fill_busy,
    output logic                   fill_req,
    output t_line_tag              fill_tag
);

    localparam int WORD_W = $clog2(`FE_LINE_WORDS);
    localparam int OFF_W  = WORD_W + 2;

    t_line_tag         req_tag;
    logic [WORD_W-1:0] req_word;
    logic              hit;
    t_rv_instr         hit_instr;

    assign req_tag  = fb.req_addr[31:OFF_W];
    assign req_word = fb.req_addr[OFF_W-1:2];

    // Tags are unique, so at most one line matches
    always_comb begin
        hit       = 1'b0;
        hit_instr = '0;
        for (int i = 0; i < `FE_LINES; i++) begin
            if (line_valid[i] && (line_tag[i] == req_tag)) begin
                hit       = 1'b1;
                hit_instr = line_words[i][req_word];
            end
        end
    end

    assign fb.rsp_valid = fb.req_valid & hit;
    assign fb.rsp_instr = hit_instr;
    assign fb.rsp_pc    = fb.req_addr;

    // Filler goes busy next cycle, which ends the pulse
    assign fill_req = fb.req_valid & ~hit & ~fill_busy;
    assign fill_tag = req_tag;

endmodule

`default_nettype wire

// ==== rtl/fe_ctl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module fe_ctl
    import fe_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  t_nuke_pkt       nuke,
    input  logic            resume_fetch,
    input  t_rob_id         oldest_robid,
    input  t_br_mispred_pkt br_mispred,
    fe_fb_if.fe             fb,
    output logic            valid_fe1,
    output t_rv_instr       instr_fe1,
    output t_paddr          pc_fe1,
    input  logic            decode_ready
);

    typedef enum logic [1:0] {
        FE_IDLE,
        FE_REQ,
        FE_PDG_NUKE
    } t_fe_state;

    t_fe_state state;
    t_fe_state state_nxt;
    t_paddr    pc;
    t_paddr    pc_seq;
    t_paddr    jal_imm;
    logic      nuke_ql;
    logic      nuke_pdg;
    logic      mispred_ql;
    logic      mispred_pdg;
    t_rob_id   mispred_robid;
    logic      accept;

    assign nuke_ql = nuke.valid & nuke.nuke_fe;

    // Only the oldest mispredict since the last nuke redirects fetch
    assign mispred_ql = br_mispred.valid & ~br_mispred.ucbr &
                        (~mispred_pdg |
                         f_robid_a_older_b(br_mispred.robid, mispred_robid, oldest_robid));

    always_ff @(posedge clk) begin
        if (reset) begin
            mispred_pdg <= 1'b0;
            nuke_pdg    <= 1'b0;
        end else begin
            mispred_pdg <= ~nuke_ql & (mispred_pdg | mispred_ql);
            nuke_pdg    <= (nuke_pdg & ~nuke_ql) | mispred_ql;
        end
    end

    always_ff @(posedge clk) begin
        if (mispred_ql) begin
            mispred_robid <= br_mispred.robid;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (state)
            FE_IDLE:     state_nxt = FE_REQ;
            FE_REQ:      if (nuke_pdg | nuke_ql) state_nxt = FE_PDG_NUKE;
            // Restart once the back end releases fetch
            FE_PDG_NUKE: if (resume_fetch) state_nxt = FE_REQ;
            default:     state_nxt = FE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // JAL predecode
    assign jal_imm = {{11{fb.rsp_instr.j.imm20}}, fb.rsp_instr.j.imm20,
                      fb.rsp_instr.j.imm19_12, fb.rsp_instr.j.imm11,
                      fb.rsp_instr.j.imm10_1, 1'b0};

    assign pc_seq = (fb.rsp_instr.gen.opcode == OP_JAL) ? pc + jal_imm : pc + 32'd4;

    assign accept = valid_fe1 & decode_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `FE_BOOT_VECTOR;
        end else if (mispred_ql) begin
            pc <= br_mispred.target_addr;
        end else if (accept) begin
            pc <= pc_seq;
        end
    end

    assign fb.req_valid = (state == FE_REQ);
    assign fb.req_addr  = pc;

    // Outputs to decode
    assign valid_fe1 = (state == FE_REQ) & fb.rsp_valid & ~nuke_pdg;
    assign instr_fe1 = fb.rsp_instr;
    assign pc_fe1    = fb.rsp_pc;

endmodule

`default_nettype wire

// ==== rtl/fe_fb_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface fe_fb_if
    import fe_pkg::*;
();

    logic      req_valid;
    t_paddr    req_addr;

    // Response is combinational off the request
    logic      rsp_valid;
    t_rv_instr rsp_instr;
    t_paddr    rsp_pc;

    modport fe (
        output req_valid,
        output req_addr,
        input  rsp_valid,
        input  rsp_instr,
        input  rsp_pc
    );

    modport fb (
        input  req_valid,
        input  req_addr,
        output rsp_valid,
        output rsp_instr,
        output rsp_pc
    );

endinterface

`default_nettype wire

// ==== rtl/fe_params.svh ====
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Fetch buffer geometry
`define FE_LINES 4
`define FE_LINE_WORDS 4

// First fetch address out of reset
`define FE_BOOT_VECTOR 32'h0000_1000

`endif

// ==== rtl/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    typedef logic [31:0] t_paddr;
    typedef logic [4:0]  t_rob_id;

    // Address bits above the 16 byte line offset
    typedef logic [27:0] t_line_tag;

    localparam logic [6:0] OP_JAL = 7'b1101111;

    typedef struct packed {
        logic [24:0] rest;
        logic [6:0]  opcode;
    } t_instr_gen;

    // J-type immediate is scattered over the upper 20 bits
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_instr_j;

    typedef union packed {
        t_instr_gen gen;
        t_instr_j   j;
    } t_rv_instr;

    typedef struct packed {
        logic    valid;
        logic    ucbr;
        t_rob_id robid;
        t_paddr  target_addr;
    } t_br_mispred_pkt;

    typedef struct packed {
        logic valid;
        logic nuke_fe;
    } t_nuke_pkt;

    // Distance from the oldest entry decides age, ids wrap at 32
    function automatic logic f_robid_a_older_b(t_rob_id a, t_rob_id b, t_rob_id oldest);
        t_rob_id dist_a;
        t_rob_id dist_b;
        dist_a = a - oldest;
        dist_b = b - oldest;
        return dist_a < dist_b;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/fe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module fe_top
    import fe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        nuke_valid,
    input  logic        nuke_fe,
    input  logic        resume_fetch,
    input  logic [4:0]  oldest_robid,
    input  logic        br_mispred_valid,
    input  logic        br_mispred_ucbr,
    input  logic [4:0]  br_mispred_robid,
    input  logic [31:0] br_mispred_target,
    output logic        valid_fe1,
    output logic [31:0] instr_fe1,
    output logic [31:0] pc_fe1,
    input  logic        decode_ready,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack
);

    localparam int WORD_W = $clog2(`FE_LINE_WORDS);

    t_nuke_pkt         nuke_pkt;
    t_br_mispred_pkt   mispred_pkt;
    t_rv_instr         instr;
    logic              fill_req;
    t_line_tag         fill_tag;
    logic              fill_busy;
    logic [`FE_LINES-1:0] line_sel;
    logic [WORD_W-1:0] wr_word_idx;
    t_rv_instr         wr_data;
    t_line_tag         wr_tag;
    logic              set_valid;
    logic [`FE_LINES-1:0] line_valid;
    t_line_tag         line_tag [`FE_LINES];
    t_rv_instr         line_words [`FE_LINES][`FE_LINE_WORDS];

    fe_fb_if fb_if ();

    assign nuke_pkt.valid   = nuke_valid;
    assign nuke_pkt.nuke_fe = nuke_fe;

    assign mispred_pkt.valid       = br_mispred_valid;
    assign mispred_pkt.ucbr        = br_mispred_ucbr;
    assign mispred_pkt.robid       = br_mispred_robid;
    assign mispred_pkt.target_addr = br_mispred_target;

    fe_ctl i_fe_ctl (
        .clk,
        .reset,
        .nuke         (nuke_pkt),
        .resume_fetch,
        .oldest_robid,
        .br_mispred   (mispred_pkt),
        .fb           (fb_if),
        .valid_fe1,
        .instr_fe1    (instr),
        .pc_fe1,
        .decode_ready
    );

    assign instr_fe1 = instr;

    fb_read i_fb_read (
        .fb         (fb_if),
        .line_valid,
        .line_tag,
        .line_words,
        .fill_busy,
        .fill_req,
        .fill_tag
    );

    fb_fill i_fb_fill (
        .clk,
        .reset,
        .fill_req,
        .fill_tag,
        .fill_busy,
        .line_sel,
        .wr_word_idx,
        .wr_data,
        .wr_tag,
        .set_valid,
        .wb_cyc,
        .wb_stb,
        .wb_we,
        .wb_adr,
        .wb_dat_i,
        .wb_ack
    );

    // Fetch buffer lines
    for (genvar i = 0; i < `FE_LINES; i++) begin : g_line
        fb_line i_line (
            .clk,
            .reset,
            .wr_en       (line_sel[i]),
            .wr_word_idx,
            .wr_data,
            .wr_tag,
            .set_valid,
            .line_valid  (line_valid[i]),
            .line_tag    (line_tag[i]),
            .line_words  (line_words[i])
        );
    end

endmodule

`default_nettype wire

// ==== tb/tb_fe.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fe_params.svh"

module tb_fe
    import fe_pkg::*;
();

    // Worst case cycles per word from the memory model
    localparam int MAX_ACK_CYC = 5;
    localparam int N_BUDGET    = 330;
    localparam int WATCHDOG_NS = N_BUDGET * (`FE_LINE_WORDS * MAX_ACK_CYC + 4) * 8;

    logic        clk;
    logic        reset;
    logic        nuke_valid;
    logic        nuke_fe;
    logic        resume_fetch;
    logic [4:0]  oldest_robid;
    logic        br_mispred_valid;
    logic        br_mispred_ucbr;
    logic [4:0]  br_mispred_robid;
    logic [31:0] br_mispred_target;
    logic        valid_fe1;
    logic [31:0] instr_fe1;
    logic [31:0] pc_fe1;
    logic        decode_ready;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [1:0]  ack_delay;

    logic [31:0] lfsr_state;
    logic [31:0] prog [1024];
    string       test_name;
    t_paddr      exp_pc;
    t_paddr      redir_pc;
    logic        redir_valid;
    logic        blocked;
    logic        mp_pdg;
    t_rob_id     mp_robid;
    logic        stall_seen;
    t_paddr      stall_pc;
    int          accepted;
    int          jal_seen;
    int          value_errors;
    int          other_errors;

    fe_top i_dut (
        .clk, .reset, .nuke_valid, .nuke_fe, .resume_fetch, .oldest_robid,
        .br_mispred_valid, .br_mispred_ucbr, .br_mispred_robid, .br_mispred_target,
        .valid_fe1, .instr_fe1, .pc_fe1, .decode_ready,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_ack
    );

    tb_fe_mem i_mem (
        .clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .adr(wb_adr),
        .dat(wb_dat_i), .ack(wb_ack), .ack_delay
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Reference PC rule: JAL adds its J immediate, anything else steps by 4
    function automatic t_paddr next_pc(input t_paddr pc, input logic [31:0] w);
        logic [31:0] imm;
        imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (w[6:0] == OP_JAL) begin
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    function automatic logic robid_older(input t_rob_id a, input t_rob_id b,
                                         input t_rob_id oldest);
        int da;
        int db;
        da = (int'(a) - int'(oldest) + 32) % 32;
        db = (int'(b) - int'(oldest) + 32) % 32;
        return da < db;
    endfunction

    function automatic t_paddr rand_target();
        logic [31:0] bits;
        bits = take_bits(10);
        return 32'h1000 | {20'd0, bits[9:0], 2'b00};
    endfunction

    task automatic check_pc(input string name, input t_paddr exp, input t_paddr act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_instr(input string name, input t_rv_instr exp, input t_rv_instr act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: instr expected %h, actual %h", name, exp, act);
        end
    endtask

    // Pulses default low, every drive lands 1 ns after the edge
    task automatic next_cycle();
        logic [31:0] bits;
        @(posedge clk);
        #1;
        bits             = take_bits(2);
        ack_delay        = bits[1:0];
        br_mispred_valid = 1'b0;
        nuke_valid       = 1'b0;
        resume_fetch     = 1'b0;
        redir_valid      = 1'b0;
    endtask

    task automatic run_accepts(input int n, input logic random_ready);
        logic [31:0] bits;
        int          goal;
        goal = accepted + n;
        while (accepted < goal) begin
            next_cycle();
            bits         = take_bits(1);
            decode_ready = random_ready ? bits[0] : 1'b1;
        end
    endtask

    task automatic send_mispredict(input logic ucbr, input t_rob_id robid, input t_paddr target);
        next_cycle();
        br_mispred_valid  = 1'b1;
        br_mispred_ucbr   = ucbr;
        br_mispred_robid  = robid;
        br_mispred_target = target;
        // Oldest non-ucbr mispredict since the last nuke owns the redirect
        if (!ucbr && (!mp_pdg || robid_older(robid, mp_robid, oldest_robid))) begin
            mp_pdg      = 1'b1;
            mp_robid    = robid;
            redir_valid = 1'b1;
            redir_pc    = target;
        end
    endtask

    task automatic nuke_and_resume();
        repeat (2) next_cycle();
        next_cycle();
        nuke_valid = 1'b1;
        nuke_fe    = 1'b1;
        mp_pdg     = 1'b0;
        repeat (2) next_cycle();
        next_cycle();
        resume_fetch = 1'b1;
    endtask

    // Compare accepted instructions against the reference stream
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_cyc && wb_we) begin
                other_errors++;
                $display("Write cycle seen on the fetch bus in test %s", test_name);
            end
            if (wb_cyc !== wb_stb) begin
                other_errors++;
                $display("Wishbone stb does not follow cyc in test %s", test_name);
            end
            if (stall_seen && !(valid_fe1 && pc_fe1 == stall_pc)) begin
                other_errors++;
                $display("Output changed while decode was stalled in test %s", test_name);
            end
            stall_seen = valid_fe1 && !decode_ready && !br_mispred_valid;
            stall_pc   = pc_fe1;
            if (valid_fe1 && decode_ready) begin
                if (blocked) begin
                    other_errors++;
                    $display("Instruction at pc %h accepted before nuke and resume in test %s",
                             pc_fe1, test_name);
                end
                check_pc(test_name, exp_pc, pc_fe1);
                check_instr(test_name, prog[exp_pc[11:2]], instr_fe1);
                if (prog[exp_pc[11:2]][6:0] == OP_JAL) begin
                    jal_seen++;
                end
                exp_pc = next_pc(exp_pc, prog[exp_pc[11:2]]);
                accepted++;
            end
            if (redir_valid) begin
                exp_pc  = redir_pc;
                blocked = 1'b1;
            end
            if (resume_fetch) begin
                blocked = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, fetch stopped making progress", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [31:0] bits;
        logic [11:0] off;
        clk = 1'b0;
        reset = 1'b1;
        nuke_valid = 1'b0;
        nuke_fe = 1'b0;
        resume_fetch = 1'b0;
        oldest_robid = 5'd0;
        br_mispred_valid = 1'b0;
        br_mispred_ucbr = 1'b0;
        br_mispred_robid = 5'd0;
        br_mispred_target = 32'd0;
        decode_ready = 1'b0;
        ack_delay = 2'd0;
        lfsr_state = 32'ha19b31df;
        exp_pc = `FE_BOOT_VECTOR;
        redir_pc = '0;
        redir_valid = 1'b0;
        blocked = 1'b0;
        mp_pdg = 1'b0;
        mp_robid = '0;
        stall_seen = 1'b0;
        stall_pc = '0;
        accepted = 0;
        jal_seen = 0;
        value_errors = 0;
        other_errors = 0;
        test_name = "boot_seq";

        // Random words, no JAL except short forward jumps past the first 4 lines
        for (int i = 0; i < 1024; i++) begin
            w = take_bits(32);
            if (w[6:0] == OP_JAL) begin
                w[2] = ~w[2];
            end
            bits = take_bits(3);
            if (i >= 16 && bits[2:0] == 3'd0) begin
                bits = take_bits(3);
                off  = 12'd8 + {7'd0, bits[2:0], 2'b00};
                w    = {1'b0, off[10:1], 1'b0, 8'h00, w[11:7], OP_JAL};
            end
            prog[i]       = w;
            i_mem.mem[i]  = w;
        end

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (valid_fe1 || wb_cyc || wb_stb) begin
            other_errors++;
            $display("Outputs not idle right after reset");
        end

        run_accepts(40, 1'b0);

        test_name = "random_ready";
        run_accepts(80, 1'b1);

        test_name = "mispredict";
        repeat (3) begin
            send_mispredict(1'b0, 5'd3, rand_target());
            nuke_and_resume();
            run_accepts(8, 1'b0);
        end

        // Ids wrap around the oldest one at 20
        test_name = "two_mispredicts";
        oldest_robid = 5'd20;
        send_mispredict(1'b0, 5'd22, rand_target());
        send_mispredict(1'b0, 5'd1, rand_target());
        nuke_and_resume();
        run_accepts(8, 1'b0);
        send_mispredict(1'b0, 5'd2, rand_target());
        send_mispredict(1'b0, 5'd25, rand_target());
        nuke_and_resume();
        run_accepts(8, 1'b0);
        send_mispredict(1'b0, 5'd22, rand_target());
        send_mispredict(1'b1, 5'd21, rand_target());
        nuke_and_resume();
        run_accepts(8, 1'b0);

        // Each pass spans more lines than the buffer holds
        test_name = "line_replace";
        repeat (3) begin
            run_accepts(24, 1'b0);
            send_mispredict(1'b0, 5'd0, `FE_BOOT_VECTOR);
            nuke_and_resume();
        end
        run_accepts(8, 1'b0);

        if (jal_seen == 0) begin
            other_errors++;
            $display("No JAL instruction reached decode");
        end
        $display("Errors: %0d value mismatches, %0d other failures, %0d instructions checked",
                 value_errors, other_errors, accepted);
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_fe_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fe_mem (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic [31:0] adr,
    output logic [31:0] dat,
    output logic        ack,
    input  logic [1:0]  ack_delay
);

    // 4 KB window, loaded by the testbench before reset ends
    logic [31:0] mem [1024];
    logic [1:0]  wait_cnt;

    // One registered ack per transfer, low for a cycle after it
    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (cyc && stb && !ack) begin
            if (wait_cnt >= ack_delay) begin
                ack      <= 1'b1;
                wait_cnt <= 2'd0;
                dat      <= mem[adr[11:2]];
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire
